/* minimig_pkg.sv */
// shared types and memory-map constants for the system-bus core, imported by every block
`default_nettype none

package minimig_pkg;

	// ------------------------------------------------
	// memory map, address bits 23..16
	// ------------------------------------------------
	localparam logic [7:0] CHIP_BASE = 8'h00;	// chip ram, up to 2 MB
	localparam logic [7:0] CHIP_LAST = 8'h1f;
	localparam logic [7:0] CIA_PAGE  = 8'hbf;	// cia-a when a12 is low
	localparam logic [7:0] SLOW_BASE = 8'hc0;	// slow ram, up to 1.5 MB
	localparam logic [7:0] SLOW_LAST = 8'hd7;
	localparam logic [7:0] RTC_PAGE  = 8'hdc;	// clock nibbles
	localparam logic [7:0] KICK_BASE = 8'hf8;	// kickstart rom image
	localparam logic [7:0] KICK_LAST = 8'hff;

	// word address bits inside one 512 KB block
	localparam int BLOCK_BITS = 18;

	localparam logic [2:0] KICK_BANK = 3'd7;	// top sram bank holds kickstart

	// reset stretch, in frames
	localparam int RESET_FRAMES = 4;
	localparam int FRAME_CNT_W  = $clog2(RESET_FRAMES + 1);

	localparam int LED_DIM_BITS = 4;	// dimmer period is 2**bits lines

	// ------------------------------------------------
	// bus types
	// ------------------------------------------------
	typedef logic [23:1] cpu_addr_t;	// 68k word address

	// one cpu cycle as seen on the pins
	typedef struct packed {
		cpu_addr_t   address;
		logic        uds;	// upper byte strobe
		logic        lds;	// lower byte strobe
		logic        r_w;	// 1 = read
		logic [15:0] wdata;
	} cpu_req_t;

	// chip_size  0..3 -> 512K, 1M, 1.5M, 2M
	// slow_size  0..3 -> none, 512K, 1M, 1.5M
	typedef struct packed {
		logic [1:0] chip_size;
		logic [1:0] slow_size;
	} mem_config_t;

	// one-hot region selects, at most one bit set
	typedef struct packed {
		logic [3:0] chip;	// one per 512K block
		logic [2:0] slow;
		logic       kick;
		logic       cia_a;
		logic       rtc;
	} region_sel_t;

	// request as presented to the sram controller
	typedef struct packed {
		logic [21:1] address;	// bank in 21..19
		logic        rd;
		logic        hwr;	// high byte write
		logic        lwr;	// low byte write
		logic [15:0] wdata;
	} ram_req_t;

endpackage

`default_nettype wire

/* syscontrol.sv */
// reset sequencer, synchronizes the reset sources and stretches system reset over frames
`default_nettype none

module syscontrol (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext,
	input  logic cpu_reset_req,
	input  logic sof,
	output logic sys_reset
);
	import minimig_pkg::*;

	logic [1:0]             src_sync;	// two stage synchronizer
	logic                   src_active;
	logic [FRAME_CNT_W-1:0] frame_cnt;

	assign src_active = src_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			src_sync  <= 2'b11;	// power-on counts as a source
			frame_cnt <= FRAME_CNT_W'(RESET_FRAMES);
		end else begin
			src_sync <= {src_sync[0], rst_ext | cpu_reset_req};
			if (src_active)
				frame_cnt <= FRAME_CNT_W'(RESET_FRAMES);	// reload while held
			else if (sof && frame_cnt != '0)
				frame_cnt <= frame_cnt - 1'b1;	// one per frame
		end
	end

	// released once the frame count runs out
	assign sys_reset = src_active || (frame_cnt != '0);

endmodule

`default_nettype wire

/* address_decoder.sv */
// combinational cpu address decode into region selects, honors overlay and fitted memory
`default_nettype none

module address_decoder (
	input  minimig_pkg::cpu_addr_t   addr,
	input  logic                     r_w,
	input  logic                     ovl,
	input  minimig_pkg::mem_config_t mem_config,
	output minimig_pkg::region_sel_t sel
);
	import minimig_pkg::*;

	logic [7:0] page;	// address bits 23..16
	logic [7:0] chip_off;
	logic [7:0] slow_off;
	logic [1:0] chip_blk;
	logic [1:0] slow_blk;
	logic       in_chip;
	logic       in_slow;

	// true when page lies in lo..hi, wrap-safe
	function automatic logic in_range(input logic [7:0] pg, input logic [7:0] lo,
		input logic [7:0] hi);
		logic [7:0] off;
		off = pg - lo;
		return off <= (hi - lo);
	endfunction

	always_comb begin
		page     = addr[23:16];
		chip_off = page - CHIP_BASE;
		slow_off = page - SLOW_BASE;
		chip_blk = chip_off[4:3];	// 512K granularity
		slow_blk = slow_off[4:3];
		in_chip  = in_range(page, CHIP_BASE, CHIP_LAST);
		in_slow  = in_range(page, SLOW_BASE, SLOW_LAST);

		sel = '0;
		// ------------------------------------------------
		// ram regions
		// ------------------------------------------------
		if (in_chip && ovl && r_w && chip_blk == 2'd0)
			sel.kick = 1'b1;	// boot overlay, rom appears at 0
		else if (in_chip && chip_blk <= mem_config.chip_size)
			sel.chip[chip_blk] = 1'b1;

		if (in_slow && slow_blk < mem_config.slow_size)
			sel.slow[slow_blk] = 1'b1;	// blocks past slow_size stay unmapped

		if (in_range(page, KICK_BASE, KICK_LAST))
			sel.kick = 1'b1;

		// ------------------------------------------------
		// register pages
		// ------------------------------------------------
		sel.cia_a = (page == CIA_PAGE) && !addr[12];
		sel.rtc   = (page == RTC_PAGE);
	end

endmodule

`default_nettype wire

/* bank_mapper.sv */
// maps region selects onto an sram bank and physical address, kickstart stays read-only
`default_nettype none

module bank_mapper (
	input  minimig_pkg::region_sel_t sel,
	input  minimig_pkg::cpu_req_t    req,
	input  logic                     ram_start,
	output minimig_pkg::ram_req_t    ram_req,
	output logic                     ram_go
);
	import minimig_pkg::*;

	logic [2:0] bank;
	logic       ram_hit;	// any sram backed region
	logic       wr_ok;

	always_comb begin
		ram_hit = (|sel.chip) || (|sel.slow) || sel.kick;

		bank = 3'd0;
		for (int i = 0; i < 4; i++)
			if (sel.chip[i]) bank = 3'(i);	// chip 0..3
		for (int i = 0; i < 3; i++)
			if (sel.slow[i]) bank = 3'(4 + i);	// slow 4..6
		if (sel.kick)
			bank = KICK_BANK;

		// rom image is write protected, the cycle still runs for the ack
		wr_ok = !req.r_w && !sel.kick;

		ram_req.address = {bank, req.address[BLOCK_BITS:1]};
		ram_req.rd      = req.r_w;
		ram_req.hwr     = wr_ok && req.uds;
		ram_req.lwr     = wr_ok && req.lds;
		ram_req.wdata   = req.wdata;
	end

	assign ram_go = ram_start && ram_hit;

endmodule

`default_nettype wire

/* sram_bridge.sv */
// fixed two-cycle access on the external async sram, strobes active high
`default_nettype none

module sram_bridge (
	input  logic                  clk,
	input  logic                  reset,
	input  minimig_pkg::ram_req_t ram_req,
	input  logic                  ram_go,
	input  logic [15:0]           ramdata_in,
	output logic                  ram_ready,
	output logic [15:0]           ram_rdata,
	output logic [21:1]           ram_address,
	output logic [15:0]           ram_data,
	output logic                  ram_bhe,
	output logic                  ram_ble,
	output logic                  ram_we,
	output logic                  ram_oe
);

	logic strobe_phase;	// high during the first access cycle

	// ------------------------------------------------
	// strobes and handshake
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_phase <= 1'b0;
			ram_ready    <= 1'b0;
			ram_oe       <= 1'b0;
			ram_we       <= 1'b0;
			ram_bhe      <= 1'b0;
			ram_ble      <= 1'b0;
		end else begin
			strobe_phase <= ram_go;
			ram_ready    <= strobe_phase;	// second cycle
			// cycle 1 asserts, cycle 2 releases everything
			ram_oe  <= ram_go && ram_req.rd;
			ram_we  <= ram_go && (ram_req.hwr || ram_req.lwr);
			ram_bhe <= ram_go && (ram_req.rd || ram_req.hwr);	// reads take both bytes
			ram_ble <= ram_go && (ram_req.rd || ram_req.lwr);
		end
	end

	// address and data held from cycle 1 onwards
	always_ff @(posedge clk) begin
		if (ram_go) begin
			ram_address <= ram_req.address;
			ram_data    <= ram_req.wdata;
		end
		if (strobe_phase)
			ram_rdata <= ramdata_in;	// sample at end of cycle 1
	end

endmodule

`default_nettype wire

/* cpu_bus_bridge.sv */
// cpu strobe/acknowledge handshake, one access in flight, collects read data from all targets
`default_nettype none

module cpu_bus_bridge (
	input  logic                     clk,
	input  logic                     reset,
	input  minimig_pkg::cpu_req_t    cpu_req,
	input  logic                     cpu_as,
	input  minimig_pkg::region_sel_t sel,
	input  logic                     ram_ready,
	input  logic [15:0]              ram_rdata,
	input  logic [7:0]               cia_rdata,
	input  logic [63:0]              rtc,
	output logic                     cpu_dtack,
	output logic [15:0]              cpu_rdata,
	output minimig_pkg::cpu_req_t    req_latched,
	output logic                     ram_start,
	output logic                     cia_wr
);
	import minimig_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LATCH,	// request held, decode settles
		ST_ACCESS,	// target running
		ST_ACK,	// dtack high, wait for strobe release
		ST_RELEASE	// last dtack cycle
	} state_t;

	state_t      state;
	logic        ram_sel;
	logic        done;
	logic [3:0]  rtc_nib;
	logic [15:0] rd_mux;

	always_comb begin
		ram_sel = (|sel.chip) || (|sel.slow) || sel.kick;
		done    = !ram_sel || ram_ready;	// register pages finish at once
		rtc_nib = rtc[{req_latched.address[5:2], 2'b00} +: 4];

		rd_mux = 16'h0000;	// unmapped reads as zero
		if (ram_sel)
			rd_mux = ram_rdata;
		else if (sel.cia_a)
			rd_mux = {8'h00, cia_rdata};	// cia-a sits on the low byte
		else if (sel.rtc)
			rd_mux = {12'h000, rtc_nib};
		if (!req_latched.r_w)
			rd_mux = 16'h0000;
	end

	// ------------------------------------------------
	// handshake fsm
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			ram_start <= 1'b0;
		end else begin
			ram_start <= 1'b0;	// single pulse
			case (state)
				ST_IDLE:    if (cpu_as) state <= ST_LATCH;
				ST_LATCH: begin
					ram_start <= ram_sel;
					state     <= ST_ACCESS;
				end
				ST_ACCESS:  if (done) state <= ST_ACK;
				ST_ACK:     if (!cpu_as) state <= ST_RELEASE;
				ST_RELEASE: state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cpu_as)
			req_latched <= cpu_req;
		if (state == ST_ACCESS && done)
			cpu_rdata <= rd_mux;	// valid for the whole dtack window
	end

	assign cpu_dtack = (state == ST_ACK) || (state == ST_RELEASE);

	// lands on the same edge that raises dtack
	assign cia_wr = (state == ST_ACCESS) && sel.cia_a && !req_latched.r_w
		&& (req_latched.uds || req_latched.lds);

endmodule

`default_nettype wire

/* cia_port_a.sv */
// cia-a port a output register (overlay and led bits) plus the dimmed power led driver
`default_nettype none

module cia_port_a (
	input  logic       clk,
	input  logic       reset,
	input  logic       cia_wr,
	input  logic [7:0] wdata,
	input  logic [3:0] reg_index,	// address bits 11..8
	input  logic       line_active,
	output logic       ovl,
	output logic [7:0] cia_rdata,
	output logic       pwr_led
);
	import minimig_pkg::*;

	logic                    led_off;	// port a bit 1, 1 = dim
	logic [LED_DIM_BITS-1:0] led_cnt;

	// ------------------------------------------------
	// port a register
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ovl     <= 1'b1;	// boot from rom image
			led_off <= 1'b1;
		end else if (cia_wr && reg_index == 4'd0) begin
			ovl     <= wdata[0];
			led_off <= wdata[1];
		end
	end

	// only pra is readable here
	assign cia_rdata = (reg_index == 4'd0) ? {6'b000000, led_off, ovl} : 8'h00;

	// ------------------------------------------------
	// power led dimmer
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			led_cnt <= '0;
		else if (line_active)
			led_cnt <= led_cnt + 1'b1;	// one step per active cycle
	end

	// full on, or lit one count in sixteen
	assign pwr_led = !led_off || (led_cnt == '0);

endmodule

`default_nettype wire

/* minimig_top.sv */
// top level of the system-bus core, connects cpu pins, sram pins and the control blocks
`default_nettype none

module minimig_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     rst_ext,
	input  logic                     cpu_reset_req,
	input  logic                     sof,
	input  logic                     line_active,
	input  minimig_pkg::mem_config_t mem_config,
	input  logic                     cpu_as,
	input  logic                     cpu_uds,
	input  logic                     cpu_lds,
	input  logic                     cpu_r_w,
	input  minimig_pkg::cpu_addr_t   cpu_address,
	input  logic [15:0]              cpu_wdata,
	input  logic [15:0]              ramdata_in,
	input  logic [63:0]              rtc,
	output logic                     cpu_dtack,
	output logic [15:0]              cpu_rdata,
	output logic [21:1]              ram_address,
	output logic [15:0]              ram_data,
	output logic                     ram_bhe,
	output logic                     ram_ble,
	output logic                     ram_we,
	output logic                     ram_oe,
	output logic                     pwr_led,
	output logic                     rst_out,
	output logic                     cpu_reset_out
);
	import minimig_pkg::*;

	cpu_req_t    cpu_req;
	cpu_req_t    req_latched;	// held for the whole access
	region_sel_t sel;
	ram_req_t    ram_req;
	logic        sys_reset;
	logic        ram_start;
	logic        ram_go;
	logic        ram_ready;
	logic [15:0] ram_rdata;
	logic        cia_wr;
	logic [7:0]  cia_rdata;
	logic        ovl;

	assign cpu_req = '{address: cpu_address, uds: cpu_uds, lds: cpu_lds,
		r_w: cpu_r_w, wdata: cpu_wdata};
	assign rst_out       = sys_reset;
	assign cpu_reset_out = sys_reset;

	// ------------------------------------------------
	// control and bus path
	// ------------------------------------------------
	syscontrol u_ctrl (.clk, .reset, .rst_ext, .cpu_reset_req, .sof, .sys_reset);

	cpu_bus_bridge u_cpu (.clk, .reset(sys_reset), .cpu_req, .cpu_as, .sel, .ram_ready,
		.ram_rdata, .cia_rdata, .rtc, .cpu_dtack, .cpu_rdata, .req_latched, .ram_start,
		.cia_wr);

	address_decoder u_dec (.addr(req_latched.address), .r_w(req_latched.r_w), .ovl,
		.mem_config, .sel);

	bank_mapper u_bmap (.sel, .req(req_latched), .ram_start, .ram_req, .ram_go);

	sram_bridge u_ram (.clk, .reset(sys_reset), .ram_req, .ram_go, .ramdata_in,
		.ram_ready, .ram_rdata, .ram_address, .ram_data, .ram_bhe, .ram_ble, .ram_we,
		.ram_oe);

	cia_port_a u_ciaa (.clk, .reset(sys_reset), .cia_wr, .wdata(req_latched.wdata[7:0]),
		.reg_index(req_latched.address[11:8]), .line_active, .ovl, .cia_rdata, .pwr_led);

endmodule

`default_nettype wire

/* tb_minimig.sv */
// simulation top that drives minimig_top against an sram model and a reference checker
`default_nettype none

module tb_minimig;
	import minimig_pkg::*;

	localparam int N_RAND     = 100;	// random accesses per mem config
	localparam int ACC_CYCLES = 12;	// worst case per bus cycle incl. release
	localparam int MAX_CYCLES = 400 + (2 * N_RAND + 60) * ACC_CYCLES + 2 * 64;

	logic        clk;
	logic        reset;
	logic        rst_ext;
	logic        cpu_reset_req;
	logic        sof;
	logic        line_active;
	mem_config_t mem_config;
	logic        cpu_as;
	logic        cpu_uds;
	logic        cpu_lds;
	logic        cpu_r_w;
	cpu_addr_t   cpu_address;
	logic [15:0] cpu_wdata;
	logic [15:0] ramdata_in;
	logic [63:0] rtc;
	logic        cpu_dtack;
	logic [15:0] cpu_rdata;
	logic [21:1] ram_address;
	logic [15:0] ram_data;
	logic        ram_bhe;
	logic        ram_ble;
	logic        ram_we;
	logic        ram_oe;
	logic        pwr_led;
	logic        rst_out;
	logic        cpu_reset_out;

	logic [15:0] sram_mem [0:(1 << 21) - 1];	// external sram with the rom image in bank 7
	logic [15:0] ref_mem  [0:(1 << 21) - 1];	// expected contents
	logic        m_ovl;	// model copy of port a
	logic        m_led_off;
	integer      seed = 32'h1b0266ef;
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_err;
	string       test_name;

	// ------------------------------------------------
	// expectation for the access in flight
	// ------------------------------------------------
	logic        pending;
	logic        exp_read;
	cpu_addr_t   exp_addr;
	logic [15:0] exp_rdata;
	int          exp_lat;
	int          start_cycle;

	minimig_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycle++;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// sram model samples the strobes once settled after the edge
	always @(posedge clk) begin
		#10;
		if (ram_we) begin
			if (ram_bhe)
				sram_mem[ram_address][15:8] = ram_data[15:8];
			if (ram_ble)
				sram_mem[ram_address][7:0] = ram_data[7:0];
		end
		ramdata_in = ram_oe ? sram_mem[ram_address] : 16'h0000;
	end

	// power-on contents with every address bit folded in
	function automatic logic [15:0] fill_word(input logic [21:1] a);
		return a[16:1] ^ {a[21:17], a[21:17], a[21:16]};
	endfunction

	function automatic cpu_addr_t word_addr(input logic [23:0] b);
		return b[23:1];
	endfunction

	// ------------------------------------------------
	// reference model
	// ------------------------------------------------
	// sram word address of a cpu address or -1 when no ram answers
	function automatic int ref_map(input cpu_addr_t a, input logic rd);
		logic [7:0] pg;
		int         blk;
		pg = a[23:16];
		if (pg <= 8'h1f) begin
			blk = pg[4:3];
			if (m_ovl && rd && blk == 0)
				return {3'd7, a[18:1]};	// rom shadows chip block 0
			if (blk <= mem_config.chip_size)
				return {3'(blk), a[18:1]};
		end else if (pg >= 8'hc0 && pg <= 8'hd7) begin
			blk = (pg - 8'hc0) >> 3;
			if (blk < mem_config.slow_size)
				return {3'(4 + blk), a[18:1]};
		end else if (pg >= 8'hf8) begin
			return {3'd7, a[18:1]};
		end
		return -1;
	endfunction

	function automatic logic [15:0] ref_read(input cpu_addr_t a);
		int phys;
		phys = ref_map(a, 1'b1);
		if (phys >= 0)
			return ref_mem[phys];
		if (a[23:16] == 8'hbf && !a[12])
			return (a[11:8] == 4'd0) ? {14'd0, m_led_off, m_ovl} : 16'h0000;
		if (a[23:16] == 8'hdc)
			return {12'h000, rtc[a[5:2] * 4 +: 4]};	// one nibble per longword
		return 16'h0000;
	endfunction

	task automatic ref_write(input cpu_addr_t a, input logic u, input logic l,
		input logic [15:0] d);
		int phys;
		phys = ref_map(a, 1'b0);
		if (phys >= 0 && a[23:16] < 8'hf8) begin	// rom image keeps its data
			if (u)
				ref_mem[phys][15:8] = d[15:8];
			if (l)
				ref_mem[phys][7:0] = d[7:0];
		end else if (a[23:16] == 8'hbf && !a[12] && a[11:8] == 4'd0 && (u || l)) begin
			m_ovl     = d[0];
			m_led_off = d[1];
		end
	endtask

	// ------------------------------------------------
	// bus driver and checker
	// ------------------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	// one cpu cycle entered and left 10 units after an edge
	task automatic bus_cycle(input cpu_addr_t a, input logic rd, input logic u, input logic l,
		input logic [15:0] d);
		exp_addr    = a;
		exp_read    = rd;
		exp_rdata   = rd ? ref_read(a) : 16'h0000;
		exp_lat     = (ref_map(a, rd) >= 0) ? 4 : 2;	// ram or register page
		start_cycle = cycle;
		pending     = 1'b1;
		cpu_address = a;
		cpu_r_w     = rd;
		cpu_uds     = u;
		cpu_lds     = l;
		cpu_wdata   = d;
		cpu_as      = 1'b1;
		do
			wait_cycles(1);
		while (!cpu_dtack);
		cpu_as = 1'b0;
		do
			wait_cycles(1);
		while (cpu_dtack);
		if (!rd)
			ref_write(a, u, l, d);
	endtask

	always @(posedge cpu_dtack) begin
		#10;
		checks++;
		assert (pending && !rst_out) else begin
			$display("acknowledge at time %0t without a request or during reset", $time);
			errors++;
		end
		assert (cycle - start_cycle - 1 == exp_lat) else begin
			$display("ERROR %0t: dtack at %h after %0d cycles, expected %0d", $time,
				{exp_addr, 1'b0}, cycle - start_cycle - 1, exp_lat);
			errors++;
		end
		assert (!exp_read || cpu_rdata === exp_rdata) else begin
			$display("ERROR %0t: read %h returned %h, expected %h", $time,
				{exp_addr, 1'b0}, cpu_rdata, exp_rdata);
			errors++;
		end
		pending = 1'b0;
	end

	task automatic open_test(input string name);
		test_name = name;
		test_err  = errors;
	endtask

	task automatic close_test();
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, test_name,
			(errors == test_err) ? "pass" : "FAIL", errors - test_err);
	endtask

	// ------------------------------------------------
	// stimulus
	// ------------------------------------------------
	initial begin
		int          n;
		int          blk;
		cpu_addr_t   a;
		cpu_addr_t   ovl_addr [6];

		for (int i = 0; i < (1 << 21); i++) begin
			sram_mem[i] = fill_word(21'(i));
			ref_mem[i]  = fill_word(21'(i));
		end
		reset         = 1'b1;
		rst_ext       = 1'b1;	// external source held through power-on
		cpu_reset_req = 1'b0;
		sof           = 1'b0;
		line_active   = 1'b0;
		mem_config.chip_size = 2'd1;	// 1 MB chip
		mem_config.slow_size = 2'd1;	// 512K slow
		cpu_as        = 1'b0;
		cpu_uds       = 1'b0;
		cpu_lds       = 1'b0;
		cpu_r_w       = 1'b1;
		cpu_address   = '0;
		cpu_wdata     = 16'h0000;
		ramdata_in    = 16'h0000;
		rtc           = {$random(seed), $random(seed)};
		m_ovl         = 1'b1;
		m_led_off     = 1'b1;
		pending       = 1'b0;

		open_test("reset sequence");
		repeat (16) @(posedge clk);
		#10;
		reset  = 1'b0;
		cpu_as = 1'b1;	// must be ignored while in reset
		wait_cycles(4);
		cpu_as = 1'b0;
		// more frames than the stretch while the source is active
		for (int f = 0; f <= RESET_FRAMES; f++) begin
			sof = 1'b1;
			wait_cycles(1);
			sof = 1'b0;
			wait_cycles(7);
			checks++;
			assert (rst_out && cpu_reset_out) else begin
				$display("reset released at time %0t while rst_ext was held", $time);
				errors++;
			end
			checks++;
			assert (!ram_we && !ram_oe && !ram_bhe && !ram_ble) else begin
				$display("sram strobes active at time %0t during reset", $time);
				errors++;
			end
		end
		rst_ext = 1'b0;
		wait_cycles(4);	// let the synchronizer drain
		for (int f = 1; f <= RESET_FRAMES; f++) begin
			sof = 1'b1;
			wait_cycles(1);
			sof = 1'b0;
			checks++;
			assert (rst_out == (f < RESET_FRAMES) && cpu_reset_out == (f < RESET_FRAMES))
			else begin
				$display("ERROR %0t: rst_out %b cpu_reset_out %b after %0d quiet frames",
					$time, rst_out, cpu_reset_out, f);
				errors++;
			end
			wait_cycles(7);
		end
		close_test();

		open_test("overlay");
		for (int k = 0; k < 6; k++)
			ovl_addr[k] = cpu_addr_t'($random(seed)) & 23'h03ffff;	// first 512K
		for (int k = 0; k < 6; k++)
			bus_cycle(ovl_addr[k], 1'b1, 1'b1, 1'b1, 16'h0000);
		bus_cycle(word_addr(24'hbfe001), 1'b0, 1'b0, 1'b1, 16'h0000);	// ovl off
		for (int k = 0; k < 6; k++)
			bus_cycle(ovl_addr[k], 1'b1, 1'b1, 1'b1, 16'h0000);
		close_test();

		open_test("random ram traffic");
		for (int c = 0; c < 2; c++) begin
			mem_config.chip_size = c ? 2'd3 : 2'd1;
			mem_config.slow_size = c ? 2'd3 : 2'd1;
			for (int k = 0; k < N_RAND; k++) begin
				n   = $random(seed);
				blk = n[3:2];
				// few offsets per block so reads hit earlier writes
				if (n[0])
					a = {3'b000, 2'(blk), 18'(n[8:4])};
				else
					a = {3'b110, 2'(blk % 3), 18'(n[8:4])};
				bus_cycle(a, n[9], n[10], n[11] | !n[10], n[31:16]);
			end
		end
		close_test();

		open_test("kickstart write protect");
		for (int k = 0; k < 4; k++) begin
			a = {5'b11111, 18'($random(seed))};
			bus_cycle(a, 1'b0, 1'b1, 1'b1, ~ref_read(a));
			bus_cycle(a, 1'b1, 1'b1, 1'b1, 16'h0000);
		end
		close_test();

		open_test("rtc and cia reads");
		for (int k = 0; k < 16; k++)
			bus_cycle(word_addr({8'hdc, 16'(k << 2)}), 1'b1, 1'b1, 1'b1, 16'h0000);
		bus_cycle(word_addr(24'hbfe001), 1'b0, 1'b0, 1'b1, 16'h0003);
		bus_cycle(word_addr(24'hbfe001), 1'b1, 1'b1, 1'b1, 16'h0000);
		bus_cycle(word_addr(24'hbfe001), 1'b0, 1'b0, 1'b1, 16'h0002);
		bus_cycle(word_addr(24'hbfe001), 1'b1, 1'b1, 1'b1, 16'h0000);
		bus_cycle(word_addr(24'hbfe101), 1'b1, 1'b1, 1'b1, 16'h0000);	// other reg
		close_test();

		open_test("power led");
		for (int p = 0; p < 2; p++) begin	// dimmed then full on
			bus_cycle(word_addr(24'hbfe001), 1'b0, 1'b0, 1'b1, p ? 16'h0000 : 16'h0002);
			line_active = 1'b1;
			n = 0;
			for (int k = 0; k < 64; k++) begin
				wait_cycles(1);
				n += pwr_led;
			end
			line_active = 1'b0;
			checks++;
			assert (n == (p ? 64 : 4)) else begin
				$display("ERROR %0t: pwr_led high on %0d of 64 cycles, expected %0d",
					$time, n, p ? 64 : 4);
				errors++;
			end
		end
		close_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
minimig_pkg.sv
syscontrol.sv
address_decoder.sv
bank_mapper.sv
sram_bridge.sv
cpu_bus_bridge.sv
cia_port_a.sv
minimig_top.sv
tb_minimig.sv

/* Bender.yml */
package:
  name: minimig_core

sources:
  - minimig_pkg.sv
  - syscontrol.sv
  - address_decoder.sv
  - bank_mapper.sv
  - sram_bridge.sv
  - cpu_bus_bridge.sv
  - cia_port_a.sv
  - minimig_top.sv
  - target: test
    files:
      - tb_minimig.sv
